// ==== commit_pkg.sv ====
// Result word, register number and ROB tag types with the port index constants of the commit stage

package commit_pkg;

    // ============================================================
    // Data path widths
    // ============================================================

    // Width of one result word produced by an execution unit
    localparam int DATA_WIDTH = 32;

    // Width of an architectural register number
    localparam int REG_ADDR_WIDTH = 5;

    // Width of a reorder buffer tag
    localparam int ROB_TAG_WIDTH = 6;

    // ============================================================
    // Scalar types
    // ============================================================

    // One result word as it is written back into the reorder buffer
    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // Destination or source register number
    // Register 0 is the hardwired zero register and never forwards data
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Reorder buffer slot that an instruction owns from dispatch to retire
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;

    // ============================================================
    // Port indices
    // ============================================================

    // Number of execution units that return results to the commit stage
    localparam int EXU_PORTS = 2;

    // The integer unit returns fixed latency results on port 0
    localparam int ITU_PORT = 0;

    // The load/store unit has a variable latency and uses port 1
    localparam int LSU_PORT = 1;

    // Number of source operands that the issue stage looks up per cycle
    localparam int FWD_PORTS = 2;

endpackage : commit_pkg

// ==== commit_buffer.sv ====
// Result FIFO of one execution port with register forwarding lookup and entry invalidation

`timescale 1ns/10ps

module commit_buffer import commit_pkg::*; #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Write side driven by the execution unit
    input  logic                        push_i,
    input  data_word_t                  result_i,
    input  reg_addr_t                   reg_dest_i,
    input  rob_tag_t                    rob_tag_i,

    // Read side driven by the arbiter
    input  logic                        pop_i,
    output data_word_t                  head_result_o,
    output reg_addr_t                   head_reg_dest_o,
    output rob_tag_t                    head_tag_o,

    // A newer result for this register is arriving on the other port
    input  logic                        invalidate_i,
    input  reg_addr_t                   invalid_reg_i,

    // Forwarding lookup for the source operands
    input  reg_addr_t [FWD_PORTS-1:0]   fwd_src_i,
    output data_word_t [FWD_PORTS-1:0]  fwd_data_o,
    output logic [FWD_PORTS-1:0]        fwd_valid_o,

    // Status
    output logic                        full_o,
    output logic                        empty_o
);

    // Pointers wrap naturally because the depth is a power of two
    localparam int PTR_WIDTH = $clog2(BUFFER_DEPTH);

    // ============================================================
    // Storage and pointers
    // ============================================================

    // Payload storage holds no reset value
    data_word_t result_mem [BUFFER_DEPTH];
    reg_addr_t  reg_mem    [BUFFER_DEPTH];
    rob_tag_t   tag_mem    [BUFFER_DEPTH];

    // One bit per slot that marks the entry as a legal forwarding source
    logic [BUFFER_DEPTH-1:0] fwd_bit_q;

    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;

    // One extra bit so that a full buffer can be told apart from an empty one
    logic [PTR_WIDTH:0]   count_q;

    logic push_en;
    logic pop_en;

    assign full_o  = (count_q == (PTR_WIDTH+1)'(BUFFER_DEPTH));
    assign empty_o = (count_q == '0);

    // A flush discards the push of the same cycle and makes any pop irrelevant
    assign push_en = push_i & ~full_o & ~flush_i;
    assign pop_en  = pop_i & ~empty_o & ~flush_i;

    // ============================================================
    // Control state
    // ============================================================

    always_ff @(posedge clk_i) begin : ctrl_regs
        if (!rst_n_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            fwd_bit_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            fwd_bit_q <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end

            if (pop_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            // Occupancy follows the net effect of push and pop
            case ({push_en, pop_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase

            // The other port now owns the newest value of this register
            // so older copies held here must stop forwarding
            if (invalidate_i) begin
                for (int i = 0; i < BUFFER_DEPTH; i++) begin
                    if (reg_mem[i] == invalid_reg_i) begin
                        fwd_bit_q[i] <= 1'b0;
                    end
                end
            end

            // A retired entry is no longer a forwarding source
            if (pop_en) begin
                fwd_bit_q[rd_ptr_q] <= 1'b0;
            end

            // The entry written in this cycle keeps its bit even under invalidation
            // Writes to the zero register never forward
            if (push_en) begin
                fwd_bit_q[wr_ptr_q] <= (reg_dest_i != '0);
            end
        end
    end : ctrl_regs

    // ============================================================
    // Payload write
    // ============================================================

    always_ff @(posedge clk_i) begin : payload_regs
        if (push_en) begin
            result_mem[wr_ptr_q] <= result_i;
            reg_mem[wr_ptr_q]    <= reg_dest_i;
            tag_mem[wr_ptr_q]    <= rob_tag_i;
        end
    end : payload_regs

    // The oldest entry is always presented to the arbiter
    assign head_result_o   = result_mem[rd_ptr_q];
    assign head_reg_dest_o = reg_mem[rd_ptr_q];
    assign head_tag_o      = tag_mem[rd_ptr_q];

    // ============================================================
    // Forwarding lookup
    // ============================================================

    // Slots are walked from oldest to youngest so that the youngest match wins
    // Free slots never match because their bit is cleared on pop and flush
    always_comb begin : fwd_lookup
        logic [PTR_WIDTH-1:0] idx;

        idx = '0;
        for (int s = 0; s < FWD_PORTS; s++) begin
            fwd_valid_o[s] = 1'b0;
            fwd_data_o[s]  = '0;

            for (int k = 0; k < BUFFER_DEPTH; k++) begin
                idx = rd_ptr_q + PTR_WIDTH'(k);

                if (fwd_bit_q[idx] && (reg_mem[idx] == fwd_src_i[s])) begin
                    fwd_valid_o[s] = 1'b1;
                    fwd_data_o[s]  = result_mem[idx];
                end
            end
        end
    end : fwd_lookup

endmodule : commit_buffer

// ==== commit_arbiter.sv ====
// Round-robin FSM that drains the ITU and LSU result FIFOs into the reorder buffer

`timescale 1ns/10ps

module commit_arbiter import commit_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    // The reorder buffer cannot take a write in this cycle
    input  logic                          stall_i,

    // Status and head entries of the result FIFOs
    input  logic [EXU_PORTS-1:0]          empty_i,
    input  data_word_t [EXU_PORTS-1:0]    head_result_i,
    input  reg_addr_t [EXU_PORTS-1:0]     head_reg_dest_i,
    input  rob_tag_t [EXU_PORTS-1:0]      head_tag_i,

    // Pop strobes back to the FIFOs
    output logic [EXU_PORTS-1:0]          pop_o,

    // Reorder buffer write port
    output logic                          rob_write_o,
    output rob_tag_t                      rob_tag_o,
    output reg_addr_t                     rob_reg_dest_o,
    output data_word_t                    rob_result_o
);

    // ============================================================
    // Turn register
    // ============================================================

    // Each state names the FIFO whose turn it is to be read
    typedef enum logic {
        ITU_TURN,
        LSU_TURN
    } arb_state_t;

    arb_state_t state_q;
    arb_state_t state_d;

    // Index of the FIFO that owns the current turn and of the one waiting
    logic sel_port;
    logic other_port;
    logic grant;

    always_ff @(posedge clk_i) begin : state_reg
        if (!rst_n_i) begin
            state_q <= ITU_TURN;
        end else if (!stall_i) begin
            state_q <= state_d;
        end
    end : state_reg

    // ============================================================
    // Selection and next turn
    // ============================================================

    assign sel_port   = (state_q == ITU_TURN) ? 1'(ITU_PORT) : 1'(LSU_PORT);
    assign other_port = (state_q == ITU_TURN) ? 1'(LSU_PORT) : 1'(ITU_PORT);

    // Only a nonempty FIFO is read and only while the ROB accepts a write
    assign grant = ~empty_i[sel_port] & ~stall_i;

    // Hand the turn over when the other FIFO has work, otherwise keep it
    always_comb begin : next_state
        state_d = state_q;
        if (!empty_i[other_port]) begin
            state_d = (state_q == ITU_TURN) ? LSU_TURN : ITU_TURN;
        end
    end : next_state

    always_comb begin : pop_decode
        pop_o           = '0;
        pop_o[sel_port] = grant;
    end : pop_decode

    // The selected head goes straight to the ROB and rob_write_o qualifies it
    assign rob_write_o    = grant;
    assign rob_tag_o      = head_tag_i[sel_port];
    assign rob_reg_dest_o = head_reg_dest_i[sel_port];
    assign rob_result_o   = head_result_i[sel_port];

endmodule : commit_arbiter

// ==== commit_stage.sv ====
// Commit stage top level with the ITU and LSU result FIFOs, the drain arbiter and forwarding merge

`timescale 1ns/10ps

module commit_stage import commit_pkg::*; #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,

    // Back-pressure from the reorder buffer and towards the execution units
    input  logic                          stall_i,
    output logic                          stall_o,

    // Results returned by the execution units
    input  logic [EXU_PORTS-1:0]          data_valid_i,
    input  data_word_t [EXU_PORTS-1:0]    result_i,
    input  reg_addr_t [EXU_PORTS-1:0]     reg_dest_i,
    input  rob_tag_t [EXU_PORTS-1:0]      rob_tag_i,

    // Reorder buffer write port
    output logic                          rob_write_o,
    output rob_tag_t                      rob_tag_o,
    output reg_addr_t                     rob_reg_dest_o,
    output data_word_t                    rob_result_o,

    // Both FIFOs hold nothing
    output logic                          buffers_empty_o,

    // Operand forwarding towards the issue stage
    input  reg_addr_t [FWD_PORTS-1:0]     fwd_src_i,
    output data_word_t [FWD_PORTS-1:0]    fwd_data_o,
    output logic [FWD_PORTS-1:0]          fwd_valid_o
);

    // ============================================================
    // Internal nets
    // ============================================================

    logic [EXU_PORTS-1:0]       buf_full;
    logic [EXU_PORTS-1:0]       buf_empty;
    logic [EXU_PORTS-1:0]       buf_pop;

    data_word_t [EXU_PORTS-1:0] head_result;
    reg_addr_t [EXU_PORTS-1:0]  head_reg_dest;
    rob_tag_t [EXU_PORTS-1:0]   head_tag;

    data_word_t [FWD_PORTS-1:0] itu_fwd_data;
    data_word_t [FWD_PORTS-1:0] lsu_fwd_data;
    logic [FWD_PORTS-1:0]       itu_fwd_valid;
    logic [FWD_PORTS-1:0]       lsu_fwd_valid;

    // ============================================================
    // Result FIFOs
    // ============================================================

    // A push on one port makes its result the newest copy of that register
    // so it invalidates the matching entries of the other FIFO
    commit_buffer #(
        .BUFFER_DEPTH    ( BUFFER_DEPTH               )
    ) itu_buffer (
        .clk_i           ( clk_i                      ),
        .rst_n_i         ( rst_n_i                    ),
        .flush_i         ( flush_i                    ),
        .push_i          ( data_valid_i[ITU_PORT]     ),
        .result_i        ( result_i[ITU_PORT]         ),
        .reg_dest_i      ( reg_dest_i[ITU_PORT]       ),
        .rob_tag_i       ( rob_tag_i[ITU_PORT]        ),
        .pop_i           ( buf_pop[ITU_PORT]          ),
        .head_result_o   ( head_result[ITU_PORT]      ),
        .head_reg_dest_o ( head_reg_dest[ITU_PORT]    ),
        .head_tag_o      ( head_tag[ITU_PORT]         ),
        .invalidate_i    ( data_valid_i[LSU_PORT]     ),
        .invalid_reg_i   ( reg_dest_i[LSU_PORT]       ),
        .fwd_src_i       ( fwd_src_i                  ),
        .fwd_data_o      ( itu_fwd_data               ),
        .fwd_valid_o     ( itu_fwd_valid              ),
        .full_o          ( buf_full[ITU_PORT]         ),
        .empty_o         ( buf_empty[ITU_PORT]        )
    );

    commit_buffer #(
        .BUFFER_DEPTH    ( BUFFER_DEPTH               )
    ) lsu_buffer (
        .clk_i           ( clk_i                      ),
        .rst_n_i         ( rst_n_i                    ),
        .flush_i         ( flush_i                    ),
        .push_i          ( data_valid_i[LSU_PORT]     ),
        .result_i        ( result_i[LSU_PORT]         ),
        .reg_dest_i      ( reg_dest_i[LSU_PORT]       ),
        .rob_tag_i       ( rob_tag_i[LSU_PORT]        ),
        .pop_i           ( buf_pop[LSU_PORT]          ),
        .head_result_o   ( head_result[LSU_PORT]      ),
        .head_reg_dest_o ( head_reg_dest[LSU_PORT]    ),
        .head_tag_o      ( head_tag[LSU_PORT]         ),
        .invalidate_i    ( data_valid_i[ITU_PORT]     ),
        .invalid_reg_i   ( reg_dest_i[ITU_PORT]       ),
        .fwd_src_i       ( fwd_src_i                  ),
        .fwd_data_o      ( lsu_fwd_data               ),
        .fwd_valid_o     ( lsu_fwd_valid              ),
        .full_o          ( buf_full[LSU_PORT]         ),
        .empty_o         ( buf_empty[LSU_PORT]        )
    );

    // ============================================================
    // Drain arbiter
    // ============================================================

    commit_arbiter arbiter (
        .clk_i           ( clk_i          ),
        .rst_n_i         ( rst_n_i        ),
        .stall_i         ( stall_i        ),
        .empty_i         ( buf_empty      ),
        .head_result_i   ( head_result    ),
        .head_reg_dest_i ( head_reg_dest  ),
        .head_tag_i      ( head_tag       ),
        .pop_o           ( buf_pop        ),
        .rob_write_o     ( rob_write_o    ),
        .rob_tag_o       ( rob_tag_o      ),
        .rob_reg_dest_o  ( rob_reg_dest_o ),
        .rob_result_o    ( rob_result_o   )
    );

    // Any full FIFO holds back both execution units
    assign stall_o         = |buf_full;
    assign buffers_empty_o = &buf_empty;

    // ============================================================
    // Forwarding merge
    // ============================================================

    // Invalidation leaves at most one valid copy across the two FIFOs
    // so the ITU is simply taken first
    always_comb begin : fwd_merge
        for (int s = 0; s < FWD_PORTS; s++) begin
            fwd_data_o[s]  = itu_fwd_valid[s] ? itu_fwd_data[s] : lsu_fwd_data[s];
            fwd_valid_o[s] = itu_fwd_valid[s] | lsu_fwd_valid[s];
        end
    end : fwd_merge

endmodule : commit_stage

// ==== tb_commit_stage.sv ====
// Self-checking testbench for the commit stage with random stimulus, a queue model and assertions

`timescale 1ns/10ps

module tb_commit_stage import commit_pkg::*; ();

    localparam int BUFFER_DEPTH = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int NUM_CYCLES   = 2000;
    localparam int DRAIN_LIMIT  = 4 * BUFFER_DEPTH + 4;

    // One buffered result as the model keeps it
    typedef struct packed {
        rob_tag_t   tag;
        reg_addr_t  rd;
        data_word_t data;
        logic       fwd;
    } entry_t;

    logic                       clk_i = 1'b0;
    logic                       rst_n_i;
    logic                       flush_i;
    logic                       stall_i;
    logic                       stall_o;
    logic [EXU_PORTS-1:0]       data_valid_i;
    data_word_t [EXU_PORTS-1:0] result_i;
    reg_addr_t [EXU_PORTS-1:0]  reg_dest_i;
    rob_tag_t [EXU_PORTS-1:0]   rob_tag_i;
    logic                       rob_write_o;
    rob_tag_t                   rob_tag_o;
    reg_addr_t                  rob_reg_dest_o;
    data_word_t                 rob_result_o;
    logic                       buffers_empty_o;
    reg_addr_t [FWD_PORTS-1:0]  fwd_src_i;
    data_word_t [FWD_PORTS-1:0] fwd_data_o;
    logic [FWD_PORTS-1:0]       fwd_valid_o;

    // Model state, one queue per result port plus the arbiter turn
    entry_t model_q [EXU_PORTS][$];
    int     turn        = ITU_PORT;
    logic   after_flush = 1'b0;
    logic   prev_both   = 1'b0;
    logic   prev_parity = 1'b0;
    int     stall_left  = 0;
    int     n_errors    = 0;
    int     n_checks    = 0;

    commit_stage #(
        .BUFFER_DEPTH    ( BUFFER_DEPTH    )
    ) dut (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .flush_i         ( flush_i         ),
        .stall_i         ( stall_i         ),
        .stall_o         ( stall_o         ),
        .data_valid_i    ( data_valid_i    ),
        .result_i        ( result_i        ),
        .reg_dest_i      ( reg_dest_i      ),
        .rob_tag_i       ( rob_tag_i       ),
        .rob_write_o     ( rob_write_o     ),
        .rob_tag_o       ( rob_tag_o       ),
        .rob_reg_dest_o  ( rob_reg_dest_o  ),
        .rob_result_o    ( rob_result_o    ),
        .buffers_empty_o ( buffers_empty_o ),
        .fwd_src_i       ( fwd_src_i       ),
        .fwd_data_o      ( fwd_data_o      ),
        .fwd_valid_o     ( fwd_valid_o     )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ============================================================
    // Checking helpers
    // ============================================================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        assert (actual === expected) else begin
            n_errors++;
            $display("ERROR %0d ns: %s expected 'h%0h, got 'h%0h", $time, name, expected, actual);
        end
    endtask

    // Youngest forwardable entry for the register, ITU searched first
    function automatic logic expected_forward(input reg_addr_t src, output data_word_t data);
        logic found;
        found = 1'b0;
        data  = '0;
        for (int p = 0; p < EXU_PORTS; p++) begin
            for (int i = model_q[p].size() - 1; i >= 0; i--) begin
                if (!found && model_q[p][i].fwd && model_q[p][i].rd == src) begin
                    found = 1'b1;
                    data  = model_q[p][i].data;
                end
            end
        end
        return found;
    endfunction

    // Stall from the ROB must block every write
    assert property (@(posedge clk_i) disable iff (!rst_n_i) stall_i |-> !rob_write_o)
    else begin
        n_errors++;
        $display("ERROR %0d ns: rob_write_o expected 'h0, got 'h1 under stall_i", $time);
    end

    task automatic check_outputs();
        logic       exp_write;
        logic       both;
        logic       exp_valid;
        data_word_t exp_data;
        exp_write = !stall_i && model_q[turn].size() != 0;
        both      = model_q[0].size() != 0 && model_q[1].size() != 0;
        check_value("rob_write_o", 32'(exp_write), 32'(rob_write_o));
        if (exp_write) begin
            check_value("rob_tag_o", 32'(model_q[turn][0].tag), 32'(rob_tag_o));
            check_value("rob_reg_dest_o", 32'(model_q[turn][0].rd), 32'(rob_reg_dest_o));
            check_value("rob_result_o", model_q[turn][0].data, rob_result_o);
        end
        // Back to back writes with both FIFOs busy must alternate ports
        if (exp_write && both && prev_both) begin
            check_value("rob_tag_o[0]", 32'(!prev_parity), 32'(rob_tag_o[0]));
        end
        prev_both = exp_write && both;
        if (exp_write) begin
            prev_parity = model_q[turn][0].tag[0];
        end
        check_value("stall_o", 32'(model_q[0].size() == BUFFER_DEPTH ||
                                   model_q[1].size() == BUFFER_DEPTH), 32'(stall_o));
        check_value("buffers_empty_o", 32'(model_q[0].size() == 0 &&
                                           model_q[1].size() == 0), 32'(buffers_empty_o));
        assert (!after_flush || (buffers_empty_o && !rob_write_o)) else begin
            n_errors++;
            $display("Output activity after a flush before any new push at %0d ns", $time);
        end
        for (int s = 0; s < FWD_PORTS; s++) begin
            exp_valid = expected_forward(fwd_src_i[s], exp_data);
            check_value($sformatf("fwd_valid_o[%0d]", s), 32'(exp_valid), 32'(fwd_valid_o[s]));
            if (exp_valid) begin
                check_value($sformatf("fwd_data_o[%0d]", s), exp_data, fwd_data_o[s]);
            end
        end
    endtask

    // Applies what the coming rising edge does to the FIFOs and the turn
    task automatic update_model();
        int     old_turn;
        logic   wrote;
        entry_t ent;
        old_turn = turn;
        wrote    = !stall_i && model_q[old_turn].size() != 0;
        if (!stall_i && model_q[1 - old_turn].size() != 0) begin
            turn = 1 - old_turn;
        end
        if (flush_i) begin
            model_q[0].delete();
            model_q[1].delete();
            after_flush = 1'b1;
        end else begin
            if (wrote) begin
                void'(model_q[old_turn].pop_front());
            end
            for (int p = 0; p < EXU_PORTS; p++) begin
                if (data_valid_i[p]) begin
                    for (int i = 0; i < model_q[1 - p].size(); i++) begin
                        if (model_q[1 - p][i].rd == reg_dest_i[p]) begin
                            model_q[1 - p][i].fwd = 1'b0;
                        end
                    end
                end
            end
            for (int p = 0; p < EXU_PORTS; p++) begin
                if (data_valid_i[p]) begin
                    assert (model_q[p].size() < BUFFER_DEPTH) else begin
                        n_errors++;
                        $display("Push on port %0d while its FIFO was full at %0d ns", p, $time);
                    end
                    ent.tag  = rob_tag_i[p];
                    ent.rd   = reg_dest_i[p];
                    ent.data = result_i[p];
                    ent.fwd  = (reg_dest_i[p] != '0);
                    model_q[p].push_back(ent);
                    after_flush = 1'b0;
                end
            end
        end
    endtask

    // Outputs are settled half a period after the inputs changed
    always @(negedge clk_i) begin : check_and_model
        if (!rst_n_i) begin
            model_q[0].delete();
            model_q[1].delete();
            turn        = ITU_PORT;
            after_flush = 1'b0;
            prev_both   = 1'b0;
        end else begin
            check_outputs();
            update_model();
        end
    end : check_and_model

    // ============================================================
    // Stimulus
    // ============================================================

    task automatic drive_random_inputs();
        reg_addr_t itu_rd;
        reg_addr_t lsu_rd;
        if (stall_left != 0) begin
            stall_left--;
            stall_i = 1'b1;
        end else if ($urandom_range(7, 0) == 0) begin
            stall_left = int'($urandom_range(5, 0));
            stall_i    = 1'b1;
        end else begin
            stall_i = 1'b0;
        end
        flush_i = ($urandom_range(59, 0) == 0);
        itu_rd  = reg_addr_t'($urandom_range(7, 0));
        lsu_rd  = reg_addr_t'($urandom_range(7, 0));
        data_valid_i[ITU_PORT] = !stall_o && $urandom_range(1, 0) == 1;
        data_valid_i[LSU_PORT] = !stall_o && $urandom_range(1, 0) == 1;
        // Two pushes in one cycle never name the same nonzero register
        if (&data_valid_i && itu_rd == lsu_rd && itu_rd != '0) begin
            lsu_rd = itu_rd + 1'b1;
        end
        reg_dest_i[ITU_PORT] = itu_rd;
        reg_dest_i[LSU_PORT] = lsu_rd;
        result_i[ITU_PORT]   = $urandom();
        result_i[LSU_PORT]   = $urandom();
        rob_tag_i[ITU_PORT]  = rob_tag_t'($urandom_range(31, 0) * 2);
        rob_tag_i[LSU_PORT]  = rob_tag_t'($urandom_range(31, 0) * 2 + 1);
        fwd_src_i[0]         = reg_addr_t'($urandom_range(7, 0));
        fwd_src_i[1]         = reg_addr_t'($urandom_range(7, 0));
    endtask

    initial begin : main_sequence
        int drain_cycles;
        void'($urandom(32'hd52c_fa76));
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        stall_i      = 1'b0;
        data_valid_i = '0;
        result_i     = '0;
        reg_dest_i   = '0;
        rob_tag_i    = '0;
        fwd_src_i    = '0;
        repeat (3) @(posedge clk_i);
        #2 rst_n_i = 1'b1;
        repeat (NUM_CYCLES) begin
            @(posedge clk_i);
            #2 drive_random_inputs();
        end
        // Let every remaining result leave before the final count
        @(posedge clk_i);
        #2;
        stall_i      = 1'b0;
        flush_i      = 1'b0;
        data_valid_i = '0;
        drain_cycles = 0;
        while (!buffers_empty_o && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk_i);
            #2 drain_cycles++;
        end
        assert (buffers_empty_o && model_q[0].size() == 0 && model_q[1].size() == 0) else begin
            n_errors++;
            $display("FIFOs did not drain within %0d cycles", DRAIN_LIMIT);
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end : main_sequence

    initial begin : watchdog
        #(CLK_PERIOD * (NUM_CYCLES + DRAIN_LIMIT + 100));
        $display("Watchdog timeout, the run did not finish in time");
        $display("Regression failed");
        $finish;
    end : watchdog

endmodule : tb_commit_stage

// ==== all.f ====
commit_pkg.sv
commit_buffer.sv
commit_arbiter.sv
commit_stage.sv
tb_commit_stage.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_commit_stage
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
